//--- program.hex
// One 32-bit instruction word per line, word 0 sits at START_PC
// addi words, JAL at words 6, 14, 23 skip ahead, word 31 jumps back to word 0
00100093
00200113
00300193
00400213
00500293
00600313
00C0006F
00800413
00900493
00A00513
00B00593
00C00613
00D00693
00E00713
014000EF
01000813
01100893
01200913
01300993
01400A13
01500A93
01600B13
01700B93
0100006F
01900C93
01A00D13
01B00D93
01C00E13
01D00E93
01E00F13
01F00F93
F85FF06F

//--- src.f
+incdir+dv
hw/cpu_pkg.sv
hw/fetch_decode_if.sv
hw/fetch_stage.sv
hw/inst_rom.sv
hw/decode_stage.sv
hw/cpu_frontend_top.sv
dv/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend \
    -f src.f -Mdir obj_dir -o sim_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_frontend)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- dv/frontend_ref.svh
// --------------------
// Reference model, included inside the testbench module body
// Image wraps on PC bits above the ROM depth, like the ROM itself
// --------------------
`ifndef FRONTEND_REF_SVH
`define FRONTEND_REF_SVH

// ROM depth, also handed to the DUT instance
localparam int REF_ADDR_W = 5;
localparam int REF_DEPTH  = 1 << REF_ADDR_W;

// LCG seed and constants
localparam logic [31:0] LCG_SEED = 32'd71;
localparam logic [31:0] LCG_MUL  = 32'd1664525;
localparam logic [31:0] LCG_INC  = 32'd1013904223;

// Own copy of the program image
inst_t       ref_image [0:REF_DEPTH-1];
logic [31:0] lcg_state;

task automatic load_image();
    $readmemh("program.hex", ref_image);
endtask

// Word stored at a byte address
function automatic inst_t image_word(input pc_t pc);
    return ref_image[pc[REF_ADDR_W+1:2]];
endfunction

// J-type immediate, 21 bits, sign-extended
function automatic pc_t jal_offset(input inst_t w);
    logic [20:0] imm;
    imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    return {{(XLEN-21){imm[20]}}, imm};
endfunction

// Next PC of the in-order walk
function automatic pc_t next_expected_pc(input pc_t pc);
    inst_t w;
    w = image_word(pc);
    if (w[6:0] == OPC_JAL) begin
        return pc + jal_offset(w);
    end
    return pc + 32'd4;
endfunction

// One LCG step, new state is the result
function automatic logic [31:0] lcg_draw();
    lcg_state = lcg_state * LCG_MUL + LCG_INC;
    return lcg_state;
endfunction

`endif

//--- dv/tb_frontend.sv
// --------------------
// Front end testbench, checks delivered words and the fetch PC after reset and flush
// --------------------
`timescale 1ns/1ns

module tb_frontend
    import cpu_pkg::*;
();

    `include "frontend_ref.svh"

    // --------------------
    // Run lengths
    // --------------------
    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 10;
    localparam int STRAIGHT_XFERS   = 50;
    localparam int RANDOM_XFERS     = 60;
    localparam int FLUSH_XFERS      = 60;
    localparam int JAL_FLUSH_ROUNDS = 4;
    localparam int ROUND_XFERS      = 8;
    // Each round also passes some words while it waits for a JAL
    localparam int PLANNED_XFERS    = STRAIGHT_XFERS + RANDOM_XFERS + FLUSH_XFERS
                                      + JAL_FLUSH_ROUNDS * 2 * ROUND_XFERS;
    localparam int XFER_BOUND       = 20;
    localparam int WATCHDOG_NS      = (RESET_CYCLES + PLANNED_XFERS * XFER_BOUND)
                                      * CLK_PERIOD;

    logic  clk;
    logic  reset;
    logic  out_ready;
    logic  flush;
    pc_t   flush_pc;
    logic  out_valid;
    pc_t   out_pc;
    inst_t out_inst;
    pc_t   debug_fs_pc;

    // Scoreboard
    pc_t  expected_pc;
    int   transfers;
    int   flushes;
    int   errors;
    logic in_reset;
    logic after_flush;
    pc_t  last_flush_pc;

    cpu_frontend_top #(
        .ROM_ADDR_W (REF_ADDR_W)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .out_ready   (out_ready),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .debug_fs_pc (debug_fs_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Byte address of a random image word
    function automatic pc_t pick_flush_pc(input logic [31:0] r);
        return START_PC + pc_t'({r[20 +: REF_ADDR_W], 2'b00});
    endfunction

    // --------------------
    // Compare, on the rising edge
    // --------------------
    always @(posedge clk) begin
        if (reset) begin
            expected_pc = START_PC;
            in_reset    = 1'b1;
            after_flush = 1'b0;
            assert (!out_valid) else begin
                errors++;
                $display("ERR %0t: out_valid high during reset", $time);
            end
        end else begin
            // Fetch PC parked one word below START_PC until the first request
            if (in_reset) begin
                assert (debug_fs_pc == START_PC - 32'd4) else begin
                    errors++;
                    $display("ERR %0t: fetch PC %h after reset, expected %h", $time,
                             debug_fs_pc, START_PC - 32'd4);
                end
                in_reset = 1'b0;
            end
            // Fetch PC reloaded from flush_pc at the flush edge
            if (after_flush) begin
                assert (debug_fs_pc == last_flush_pc) else begin
                    errors++;
                    $display("ERR %0t: fetch PC %h after flush, expected %h", $time,
                             debug_fs_pc, last_flush_pc);
                end
            end
            after_flush   = flush;
            last_flush_pc = flush_pc;
            if (flush) begin
                // Nothing counted, walk restarts at flush_pc
                flushes++;
                assert (!out_valid) else begin
                    errors++;
                    $display("ERR %0t: out_valid high in a flush cycle", $time);
                end
                expected_pc = flush_pc;
            end else if (out_valid && out_ready) begin
                assert (out_pc == expected_pc) else begin
                    errors++;
                    $display("ERR %0t: out_pc %h, expected %h", $time, out_pc, expected_pc);
                end
                assert (out_inst == image_word(expected_pc)) else begin
                    errors++;
                    $display("ERR %0t: out_inst %h at %h, expected %h", $time, out_inst,
                             expected_pc, image_word(expected_pc));
                end
                expected_pc = next_expected_pc(expected_pc);
                transfers++;
            end
        end
    end

    // --------------------
    // Stimulus, driven on the falling edge
    // --------------------
    initial begin
        int          goal;
        int          round;
        logic [31:0] rnd;
        clk       = 1'b0;
        reset     = 1'b1;
        out_ready = 1'b0;
        flush     = 1'b0;
        flush_pc  = START_PC;
        transfers = 0;
        flushes   = 0;
        errors    = 0;
        lcg_state = LCG_SEED;
        load_image();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Straight line and JALs, consumer always ready
        out_ready = 1'b1;
        goal = STRAIGHT_XFERS;
        while (transfers < goal) @(negedge clk);

        // Random back-pressure
        goal += RANDOM_XFERS;
        while (transfers < goal) begin
            @(negedge clk);
            rnd = lcg_draw();
            out_ready = rnd[16];
        end

        // Back-pressure plus one-cycle flushes, roughly 1 in 8 cycles
        goal += FLUSH_XFERS;
        while (transfers < goal) begin
            @(negedge clk);
            rnd = lcg_draw();
            out_ready = rnd[16];
            flush     = (rnd[10:8] == 3'd0);
            flush_pc  = pick_flush_pc(rnd);
        end
        flush     = 1'b0;
        out_ready = 1'b1;

        // Flush lands while decode offers a JAL
        for (round = 0; round < JAL_FLUSH_ROUNDS; round++) begin
            do begin
                @(negedge clk);
            end while (!(out_valid && out_inst[6:0] == OPC_JAL));
            rnd = lcg_draw();
            flush_pc = pick_flush_pc(rnd);
            // Restart point kept apart from the JAL target
            if (flush_pc == next_expected_pc(expected_pc)) begin
                flush_pc = flush_pc + 32'd4;
            end
            flush    = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            goal = transfers + ROUND_XFERS;
            while (transfers < goal) @(negedge clk);
        end

        $display("Done: %0d transfers, %0d flushes, %0d errors", transfers, flushes, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns, %0d transfers seen",
                 WATCHDOG_NS, transfers);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- hw/cpu_frontend_top.sv
// --------------------
// Front end top, fetch + ROM + decode, plain ports only
// First out_valid comes a few cycles after reset, latency not fixed
// --------------------
`timescale 1ns/1ns

module cpu_frontend_top
    import cpu_pkg::*;
#(
    parameter int ROM_ADDR_W = 5
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  out_ready,
    input  logic  flush,
    input  pc_t   flush_pc,
    output logic  out_valid,
    output pc_t   out_pc,
    output inst_t out_inst,
    output pc_t   debug_fs_pc
);

    // ROM link
    logic  inst_en;
    pc_t   inst_addr;
    inst_t inst_rdata;

    // Fetch to decode and branch back-channel
    fetch_decode_if fd ();

    // --------------------
    // Stages
    // --------------------

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fd          (fd.fetch),
        .inst_en     (inst_en),
        .inst_addr   (inst_addr),
        .inst_rdata  (inst_rdata),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .debug_fs_pc (debug_fs_pc)
    );

    inst_rom #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) u_rom (
        .clk   (clk),
        .en    (inst_en),
        .addr  (inst_addr),
        .rdata (inst_rdata)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .fd        (fd.decode),
        .flush     (flush),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst)
    );

endmodule

//--- hw/decode_stage.sv
// --------------------
// Decode register with output handshake, JAL redirect sent as it leaves
// Flush empties the stage and masks out_valid in the same cycle
// --------------------
`timescale 1ns/1ns

module decode_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    fetch_decode_if.decode fd,
    input  logic  flush,
    input  logic  out_ready,
    output logic  out_valid,
    output pc_t   out_pc,
    output inst_t out_inst
);

    logic    ds_full;
    pc_t     ds_pc;
    inst_t   ds_inst;
    logic    ds_leave;
    logic    ds_allowin;
    logic    ds_is_jal;
    opcode_t ds_opcode;
    pc_t     j_imm;

    // --------------------
    // Handshake
    // --------------------

    // Nothing leaves during a flush
    assign out_valid = ds_full && !flush;
    assign ds_leave  = out_valid && out_ready;

    // Empty, or current word goes out this edge
    assign ds_allowin    = !ds_full || ds_leave;
    assign fd.ds_allowin = ds_allowin;

    // --------------------
    // Stage register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_full <= 1'b0;
        end else if (flush) begin
            ds_full <= 1'b0;
        end else if (ds_allowin) begin
            ds_full <= fd.fs_valid;
        end
    end

    // Payload only, valid bit qualifies it
    always_ff @(posedge clk) begin
        if (ds_allowin && fd.fs_valid) begin
            ds_pc   <= fd.fs_pc;
            ds_inst <= fd.fs_inst;
        end
    end

    assign out_pc   = ds_pc;
    assign out_inst = ds_inst;

    // --------------------
    // JAL resolve
    // --------------------

    assign ds_opcode = ds_inst[6:0];
    assign ds_is_jal = (ds_opcode == OPC_JAL);

    // imm[20|10:1|11|19:12], bit 0 always zero
    assign j_imm = {{11{ds_inst[31]}},
                    ds_inst[31],
                    ds_inst[19:12],
                    ds_inst[20],
                    ds_inst[30:21],
                    1'b0};

    // Strobe only in the cycle the JAL itself is delivered
    assign fd.br_taken  = ds_leave && ds_is_jal;
    assign fd.br_target = ds_pc + j_imm;

    // --------------------
    // Checks
    // --------------------

    // A redirect comes from a live JAL, and fetch's stale word never follows it
    a_br_from_jal: assert property (
        @(posedge clk) disable iff (reset)
        fd.br_taken |-> ds_full && ds_is_jal ##1 !ds_full
    ) else $error("decode: br_taken without a JAL or with a stale follower");

    // Flush blocks delivery and the fetch offer and empties the pipe
    a_flush_kill: assert property (
        @(posedge clk) disable iff (reset)
        flush |-> !out_valid && !fd.fs_valid ##1 !out_valid
    ) else $error("decode: out_valid or fetch offer around a flush");

endmodule

//--- hw/inst_rom.sv
// --------------------
// Word-addressed ROM with registered read, contents from program.hex
// Upper PC bits wrap, only 2^ROM_ADDR_W words exist
// --------------------
`timescale 1ns/1ns

module inst_rom
    import cpu_pkg::*;
#(
    parameter int ROM_ADDR_W = 5
) (
    input  logic  clk,
    input  logic  en,
    input  pc_t   addr,
    output inst_t rdata
);

    localparam int DEPTH = 1 << ROM_ADDR_W;

    // Word index, byte offset bits dropped
    logic [ROM_ADDR_W-1:0] word_addr;

    inst_t mem [0:DEPTH-1];

    // --------------------
    // Contents
    // --------------------

    initial begin
        $readmemh("program.hex", mem);
    end

    // --------------------
    // Read port
    // --------------------

    assign word_addr = addr[ROM_ADDR_W+1:2];

    // Data holds when en is low so a stalled fetch sees a stable word
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

//--- hw/fetch_stage.sv
// --------------------
// Fetch stage, one instruction deep, ROM read data arrives one cycle late
// Next PC priority is flush, then branch, then PC+4
// --------------------
`timescale 1ns/1ns

module fetch_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    fetch_decode_if.fetch fd,
    output logic     inst_en,
    output pc_t      inst_addr,
    input  inst_t    inst_rdata,
    input  logic     flush,
    input  pc_t      flush_pc,
    output pc_t      debug_fs_pc
);

    logic fetch_go;
    logic fs_full;
    logic fs_allowin;
    logic redirect;
    pc_t  fs_pc;
    pc_t  seq_pc;
    pc_t  next_pc;

    // --------------------
    // Pre-fetch
    // --------------------

    // Goes high one cycle after reset drops, then stays
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_go <= 1'b0;
        end else begin
            fetch_go <= 1'b1;
        end
    end

    assign redirect = flush || fd.br_taken;
    assign seq_pc   = fs_pc + pc_t'(INST_BYTES);

    // Flush wins over a JAL leaving decode in the same cycle
    assign next_pc = flush       ? flush_pc     :
                     fd.br_taken ? fd.br_target :
                                   seq_pc;

    // --------------------
    // Fetch register
    // --------------------

    // A redirect reloads even when decode is stalled
    assign fs_allowin = !fs_full || fd.ds_allowin || redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_full <= 1'b0;
        end else if (fs_allowin) begin
            fs_full <= fetch_go;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= RESET_PC;
        end else if (fetch_go && fs_allowin) begin
            fs_pc <= next_pc;
        end
    end

    // ROM request goes out with the PC it will be tagged with
    assign inst_en   = fetch_go && fs_allowin;
    assign inst_addr = next_pc;

    // Held word is dropped on a redirect, the new PC loads at the same edge
    assign fd.fs_valid = fs_full && !redirect;
    assign fd.fs_pc    = fs_pc;
    assign fd.fs_inst  = inst_rdata;

    assign debug_fs_pc = fs_pc;

    // --------------------
    // Checks
    // --------------------

    // No ROM traffic while reset is applied
    a_no_req_in_reset: assert property (@(posedge clk) reset |-> !inst_en)
        else $error("fetch: inst_en high during reset");

    // Stalled instruction and PC stay put until decode frees up
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (reset)
        fs_full && !fd.ds_allowin && !redirect
            |=> fs_full && $stable(fs_pc) && $stable(inst_rdata)
    ) else $error("fetch: instruction lost while stalled");

endmodule

//--- hw/fetch_decode_if.sv
// --------------------
// Fetch to decode channel plus the branch back-channel
// br_taken is a one-cycle strobe, never held
// --------------------
`timescale 1ns/1ns

interface fetch_decode_if
    import cpu_pkg::*;
();

    // Forward path, fetch to decode
    logic  fs_valid;
    pc_t   fs_pc;
    inst_t fs_inst;

    // Decode can take a new instruction this cycle
    logic  ds_allowin;

    // Redirect back to fetch, JAL resolved in decode
    logic  br_taken;
    pc_t   br_target;

    modport fetch (
        output fs_valid,
        output fs_pc,
        output fs_inst,
        input  ds_allowin,
        input  br_taken,
        input  br_target
    );

    modport decode (
        input  fs_valid,
        input  fs_pc,
        input  fs_inst,
        output ds_allowin,
        output br_taken,
        output br_target
    );

endinterface

//--- hw/cpu_pkg.sv
// --------------------
// Widths and encodings shared by the RV32 front end
// Only JAL is decoded; other opcodes pass through untouched
// --------------------
package cpu_pkg;

    // --------------------
    // Widths
    // --------------------

    // Data and address width
    localparam int XLEN = 32;

    // One instruction word, no compressed encodings
    localparam int ILEN = 32;

    // Bytes per instruction, step of the sequential PC
    localparam int INST_BYTES = ILEN / 8;

    // Width of the major opcode field
    localparam int OPC_W = 7;

    // --------------------
    // Vector types
    // --------------------

    // Byte address of an instruction
    typedef logic [XLEN-1:0] pc_t;

    // Raw instruction word
    typedef logic [ILEN-1:0] inst_t;

    // Major opcode, inst[6:0]
    typedef logic [OPC_W-1:0] opcode_t;

    // --------------------
    // Addresses and encodings
    // --------------------

    // First fetch after reset lands here
    localparam pc_t START_PC = 32'h8000_0000;

    // PC register value in reset, one word before START_PC
    localparam pc_t RESET_PC = START_PC - pc_t'(INST_BYTES);

    // JAL major opcode
    localparam opcode_t OPC_JAL = 7'b110_1111;

endpackage
